//--- source/dm_dmi_pkg.sv
package dm_dmi_pkg;

    ////////////////////
    // Bus widths
    ////////////////////

    localparam int DMI_ADDR_W = 7;
    localparam int DMI_DATA_W = 32;

    // DMI operation field
    typedef enum logic [1:0] {
        NOP   = 2'b00,
        READ  = 2'b01,
        WRITE = 2'b10
    } dmi_op_e;

    ////////////////////
    // Register map
    ////////////////////

    localparam logic [DMI_ADDR_W-1:0] ADDR_DATA0      = 7'h04;
    localparam logic [DMI_ADDR_W-1:0] ADDR_DMCONTROL  = 7'h10;
    localparam logic [DMI_ADDR_W-1:0] ADDR_DMSTATUS   = 7'h11;
    localparam logic [DMI_ADDR_W-1:0] ADDR_ABSTRACTCS = 7'h16;
    localparam logic [DMI_ADDR_W-1:0] ADDR_COMMAND    = 7'h17;

    // Request from the DMI side for one cycle per access
    typedef struct packed {
        logic                  valid;
        dmi_op_e               op;
        logic [DMI_ADDR_W-1:0] address;
        logic [DMI_DATA_W-1:0] data;
    } dmi_req_t;

    // Response in the same cycle as the request
    typedef struct packed {
        logic                  valid;
        dmi_op_e               op;
        logic [DMI_DATA_W-1:0] data;
    } dmi_rsp_t;

endpackage

//--- source/dm_reg_pkg.sv
package dm_reg_pkg;

    ////////////////////
    // Debug registers
    ////////////////////

    typedef struct packed {
        logic        haltreq;
        logic        resumereq;
        logic [28:0] rsv_29_1;
        logic        dmactive;
    } dmcontrol_t;

    // Only the "all" flags are kept for a single hart
    typedef struct packed {
        logic [13:0] rsv_31_18;
        logic        allresumeack;
        logic [4:0]  rsv_16_12;
        logic        allrunning;
        logic        rsv_10;
        logic        allhalted;
        logic [8:0]  rsv_8_0;
    } dmstatus_t;

    typedef struct packed {
        logic [18:0] rsv_31_13;
        logic        busy;
        logic [11:0] rsv_11_0;
    } abstractcs_t;

    // Access register control field of the command
    typedef struct packed {
        logic        rsv_23;
        logic [2:0]  size;
        logic        rsv_19;
        logic        postexec;
        logic        transfer;
        logic        write;
        logic [15:0] regno;
    } access_reg_t;

    typedef struct packed {
        logic [7:0]  cmdtype;
        access_reg_t control;
    } command_t;

    localparam logic [7:0] CMDTYPE_ACCESS_REG = 8'd0;

    ////////////////////
    // Hart control
    ////////////////////

    typedef enum logic [2:0] {
        NORMAL,
        HALTING,
        HALTED,
        RESUMING,
        CMD_START,
        CMD_TRANSFER,
        CMD_DONE
    } hart_state_e;

    typedef struct packed {
        logic halt_req;
        logic all_halted;
        logic all_running;
        logic busy;
        logic clear_run_ctl;
        logic xfer_en;
    } hart_ctl_t;

endpackage

//--- source/dm_hart_ctrl.sv
`timescale 1ns/1ps

module dm_hart_ctrl (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  dm_reg_pkg::dmcontrol_t dmcontrol_i,
    input  dm_reg_pkg::command_t   command_i,
    input  logic                   cmd_valid_i,
    input  logic                   core_halt_ack_i,
    input  logic                   core_resume_ack_i,
    input  logic                   core_ebreak_i,
    output dm_reg_pkg::hart_ctl_t  ctl_o
);

    dm_reg_pkg::hart_state_e state_q;
    dm_reg_pkg::hart_state_e state_d;
    logic                    resume_ok;
    logic                    access_reg_cmd;

    // A pending haltreq wins over resumereq
    assign resume_ok      = dmcontrol_i.resumereq && !dmcontrol_i.haltreq;
    assign access_reg_cmd = cmd_valid_i &&
                            (command_i.cmdtype == dm_reg_pkg::CMDTYPE_ACCESS_REG);

    ////////////////////
    // Next state
    ////////////////////

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            dm_reg_pkg::NORMAL: begin
                if (dmcontrol_i.dmactive && (dmcontrol_i.haltreq || core_ebreak_i)) begin
                    state_d = dm_reg_pkg::HALTING;
                end
            end
            dm_reg_pkg::HALTING: begin
                if (core_halt_ack_i) begin
                    state_d = dm_reg_pkg::HALTED;
                end
            end
            dm_reg_pkg::HALTED: begin
                if (resume_ok) begin
                    state_d = dm_reg_pkg::RESUMING;
                end else if (access_reg_cmd) begin
                    state_d = dm_reg_pkg::CMD_START;
                end
            end
            dm_reg_pkg::RESUMING: begin
                if (core_resume_ack_i) begin
                    state_d = dm_reg_pkg::NORMAL;
                end
            end
            dm_reg_pkg::CMD_START: begin
                state_d = command_i.control.transfer ? dm_reg_pkg::CMD_TRANSFER
                                                     : dm_reg_pkg::CMD_DONE;
            end
            dm_reg_pkg::CMD_TRANSFER: state_d = dm_reg_pkg::CMD_DONE;
            dm_reg_pkg::CMD_DONE:     state_d = dm_reg_pkg::HALTED;
            default:                  state_d = dm_reg_pkg::NORMAL;
        endcase
    end

    always_ff @(posedge clk_i or negedge reset_i) begin
        if (!reset_i) begin
            state_q <= dm_reg_pkg::NORMAL;
        end else begin
            state_q <= state_d;
        end
    end

    ////////////////////
    // Output decode
    ////////////////////

    always_comb begin
        ctl_o = '0;
        unique case (state_q)
            dm_reg_pkg::NORMAL: ctl_o.all_running = 1'b1;
            dm_reg_pkg::HALTING: ctl_o.halt_req = 1'b1;
            dm_reg_pkg::HALTED: begin
                ctl_o.halt_req   = 1'b1;
                ctl_o.all_halted = 1'b1;
            end
            // Halt request drops so the core can leave debug mode
            dm_reg_pkg::RESUMING: begin
                ctl_o.all_halted    = 1'b1;
                ctl_o.clear_run_ctl = 1'b1;
            end
            dm_reg_pkg::CMD_START, dm_reg_pkg::CMD_TRANSFER, dm_reg_pkg::CMD_DONE: begin
                ctl_o.halt_req   = 1'b1;
                ctl_o.all_halted = 1'b1;
                ctl_o.busy       = 1'b1;
                ctl_o.xfer_en    = (state_q == dm_reg_pkg::CMD_TRANSFER) &&
                                   command_i.control.transfer;
            end
            default: ctl_o.all_running = 1'b1;
        endcase
    end

    // Transfer only in the cycle right after CMD_START
    a_xfer_in_cmd: assert property (@(posedge clk_i) disable iff (!reset_i)
        ctl_o.xfer_en |-> ($past(state_q) == dm_reg_pkg::CMD_START));

    // Clearing run control only follows a halted hart
    a_clear_in_resume: assert property (@(posedge clk_i) disable iff (!reset_i)
        ctl_o.clear_run_ctl |->
            ($past(state_q) inside {dm_reg_pkg::HALTED, dm_reg_pkg::RESUMING}));

endmodule

//--- source/dm_dmi_regfile.sv
`timescale 1ns/1ps

module dm_dmi_regfile (
    input  logic                              clk_i,
    input  logic                              reset_i,
    input  dm_dmi_pkg::dmi_req_t              dmi_req_i,
    input  dm_reg_pkg::hart_ctl_t             ctl_i,
    input  logic [dm_dmi_pkg::DMI_DATA_W-1:0] core_rd_data_i,
    output dm_reg_pkg::dmcontrol_t            dmcontrol_o,
    output dm_reg_pkg::command_t              command_o,
    output logic [dm_dmi_pkg::DMI_DATA_W-1:0] data0_o,
    output logic                              cmd_valid_o,
    output logic                              core_rd_wr_en_o,
    output logic                              core_rd_wr_o,
    output logic [15:0]                       core_rd_wr_address_o,
    output logic [dm_dmi_pkg::DMI_DATA_W-1:0] core_wr_data_o
);

    logic                              dmi_wr;
    logic                              dmcontrol_wr;
    logic                              command_wr;
    logic                              data0_hit;
    logic                              data0_wr;
    logic                              data0_load;
    dm_reg_pkg::dmcontrol_t            dmcontrol_q;
    dm_reg_pkg::dmcontrol_t            dmcontrol_d;
    dm_reg_pkg::command_t              command_q;
    logic [dm_dmi_pkg::DMI_DATA_W-1:0] data0_q;
    logic                              cmd_valid_q;

    assign dmi_wr       = dmi_req_i.valid && (dmi_req_i.op == dm_dmi_pkg::WRITE);
    assign dmcontrol_wr = dmi_wr && (dmi_req_i.address == dm_dmi_pkg::ADDR_DMCONTROL);
    assign data0_hit    = dmi_wr && (dmi_req_i.address == dm_dmi_pkg::ADDR_DATA0);

    // Command and Data0 are locked while a command runs
    assign command_wr = dmi_wr && !ctl_i.busy &&
                        (dmi_req_i.address == dm_dmi_pkg::ADDR_COMMAND);
    assign data0_wr   = data0_hit && !ctl_i.busy;

    // Register read from the core lands in Data0
    assign data0_load = ctl_i.xfer_en && !command_q.control.write;

    always_comb begin
        dmcontrol_d = dmcontrol_q;
        if (dmcontrol_wr) begin
            dmcontrol_d = dm_reg_pkg::dmcontrol_t'(dmi_req_i.data);
        end
        if (ctl_i.clear_run_ctl) begin
            dmcontrol_d.haltreq   = 1'b0;
            dmcontrol_d.resumereq = 1'b0;
        end
    end

    ////////////////////
    // Storage
    ////////////////////

    always_ff @(posedge clk_i or negedge reset_i) begin
        if (!reset_i) begin
            dmcontrol_q <= '0;
            command_q   <= '0;
            data0_q     <= '0;
            cmd_valid_q <= 1'b0;
        end else begin
            dmcontrol_q <= dmcontrol_d;
            cmd_valid_q <= command_wr;
            if (command_wr) begin
                command_q <= dm_reg_pkg::command_t'(dmi_req_i.data);
            end
            if (data0_load) begin
                data0_q <= core_rd_data_i;
            end else if (data0_wr) begin
                data0_q <= dmi_req_i.data;
            end
        end
    end

    assign dmcontrol_o = dmcontrol_q;
    assign command_o   = command_q;
    assign data0_o     = data0_q;
    assign cmd_valid_o = cmd_valid_q;

    // Core register port
    assign core_rd_wr_en_o      = ctl_i.xfer_en;
    assign core_rd_wr_o         = command_q.control.write;
    assign core_rd_wr_address_o = command_q.control.regno;
    assign core_wr_data_o       = command_q.control.write ? data0_q : '0;

    a_data0_locked: assert property (@(posedge clk_i) disable iff (!reset_i)
        (data0_hit && ctl_i.busy && !data0_load) |=> (data0_q == $past(data0_q)));

endmodule

//--- source/dm_status_read.sv
`timescale 1ns/1ps

module dm_status_read (
    input  logic                              clk_i,
    input  logic                              reset_i,
    input  dm_dmi_pkg::dmi_req_t              dmi_req_i,
    input  dm_reg_pkg::hart_ctl_t             ctl_i,
    input  logic                              core_resume_ack_i,
    input  dm_reg_pkg::dmcontrol_t            dmcontrol_i,
    input  dm_reg_pkg::command_t              command_i,
    input  logic [dm_dmi_pkg::DMI_DATA_W-1:0] data0_i,
    output dm_dmi_pkg::dmi_rsp_t              dmi_rsp_o
);

    dm_reg_pkg::dmstatus_t             dmstatus_q;
    dm_reg_pkg::abstractcs_t           abstractcs_q;
    logic                              dmi_rd;
    logic [dm_dmi_pkg::DMI_DATA_W-1:0] rd_data;

    // Status flags trail the hart state by one cycle
    always_ff @(posedge clk_i or negedge reset_i) begin
        if (!reset_i) begin
            dmstatus_q   <= '0;
            abstractcs_q <= '0;
        end else begin
            dmstatus_q.allhalted    <= ctl_i.all_halted;
            dmstatus_q.allrunning   <= ctl_i.all_running;
            dmstatus_q.allresumeack <= core_resume_ack_i;
            abstractcs_q.busy       <= ctl_i.busy;
        end
    end

    ////////////////////
    // Read mux
    ////////////////////

    assign dmi_rd = dmi_req_i.valid && (dmi_req_i.op == dm_dmi_pkg::READ);

    always_comb begin
        unique case (dmi_req_i.address)
            dm_dmi_pkg::ADDR_DATA0:      rd_data = ctl_i.busy ? '0 : data0_i;
            dm_dmi_pkg::ADDR_DMCONTROL:  rd_data = dmcontrol_i;
            dm_dmi_pkg::ADDR_DMSTATUS:   rd_data = dmstatus_q;
            dm_dmi_pkg::ADDR_ABSTRACTCS: rd_data = abstractcs_q;
            dm_dmi_pkg::ADDR_COMMAND:    rd_data = command_i;
            default:                     rd_data = '0;
        endcase
    end

    assign dmi_rsp_o.valid = dmi_rd;
    assign dmi_rsp_o.op    = dmi_req_i.op;
    assign dmi_rsp_o.data  = dmi_rd ? rd_data : '0;

    // Halted and running never show together in DMStatus
    a_status_exclusive: assert property (@(posedge clk_i) disable iff (!reset_i)
        !(dmstatus_q.allhalted && dmstatus_q.allrunning));

endmodule

//--- source/dm_top.sv
`timescale 1ns/1ps

module dm_top (
    input  logic                                  clk_i,
    input  logic                                  reset_i,

    // DMI request
    input  logic                                  dmi_req_valid_i,
    input  dm_dmi_pkg::dmi_op_e                   dmi_req_op_i,
    input  logic [dm_dmi_pkg::DMI_ADDR_W-1:0]     dmi_req_address_i,
    input  logic [dm_dmi_pkg::DMI_DATA_W-1:0]     dmi_req_data_i,

    // DMI response
    output logic                                  dmi_rsp_valid_o,
    output dm_dmi_pkg::dmi_op_e                   dmi_rsp_op_o,
    output logic [dm_dmi_pkg::DMI_DATA_W-1:0]     dmi_rsp_data_o,

    // Hart side
    input  logic                                  core_halt_ack_i,
    input  logic                                  core_resume_ack_i,
    input  logic                                  core_ebreak_i,
    input  logic [dm_dmi_pkg::DMI_DATA_W-1:0]     core_rd_data_i,
    output logic                                  core_halt_req_o,
    output logic                                  core_rd_wr_en_o,
    output logic                                  core_rd_wr_o,
    output logic [15:0]                           core_rd_wr_address_o,
    output logic [dm_dmi_pkg::DMI_DATA_W-1:0]     core_wr_data_o
);

    dm_dmi_pkg::dmi_req_t              dmi_req;
    dm_dmi_pkg::dmi_rsp_t              dmi_rsp;
    dm_reg_pkg::hart_ctl_t             ctl;
    dm_reg_pkg::dmcontrol_t            dmcontrol;
    dm_reg_pkg::command_t              command;
    logic [dm_dmi_pkg::DMI_DATA_W-1:0] data0;
    logic                              cmd_valid;

    assign dmi_req.valid   = dmi_req_valid_i;
    assign dmi_req.op      = dmi_req_op_i;
    assign dmi_req.address = dmi_req_address_i;
    assign dmi_req.data    = dmi_req_data_i;

    assign dmi_rsp_valid_o = dmi_rsp.valid;
    assign dmi_rsp_op_o    = dmi_rsp.op;
    assign dmi_rsp_data_o  = dmi_rsp.data;

    assign core_halt_req_o = ctl.halt_req;

    dm_hart_ctrl u_hart_ctrl (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .dmcontrol_i       (dmcontrol),
        .command_i         (command),
        .cmd_valid_i       (cmd_valid),
        .core_halt_ack_i   (core_halt_ack_i),
        .core_resume_ack_i (core_resume_ack_i),
        .core_ebreak_i     (core_ebreak_i),
        .ctl_o             (ctl)
    );

    dm_dmi_regfile u_regfile (
        .clk_i                (clk_i),
        .reset_i              (reset_i),
        .dmi_req_i            (dmi_req),
        .ctl_i                (ctl),
        .core_rd_data_i       (core_rd_data_i),
        .dmcontrol_o          (dmcontrol),
        .command_o            (command),
        .data0_o              (data0),
        .cmd_valid_o          (cmd_valid),
        .core_rd_wr_en_o      (core_rd_wr_en_o),
        .core_rd_wr_o         (core_rd_wr_o),
        .core_rd_wr_address_o (core_rd_wr_address_o),
        .core_wr_data_o       (core_wr_data_o)
    );

    dm_status_read u_status_read (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .dmi_req_i         (dmi_req),
        .ctl_i             (ctl),
        .core_resume_ack_i (core_resume_ack_i),
        .dmcontrol_i       (dmcontrol),
        .command_i         (command),
        .data0_i           (data0),
        .dmi_rsp_o         (dmi_rsp)
    );

endmodule

//--- test/dm_checker.sv
`timescale 1ns/1ps

module dm_checker (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                active_i,
    input  logic [95:0]         name_i,
    input  logic                dmi_req_valid_i,
    input  dm_dmi_pkg::dmi_op_e dmi_req_op_i,
    input  logic                dmi_rsp_valid_i,
    input  dm_dmi_pkg::dmi_op_e dmi_rsp_op_i,
    input  logic [31:0]         dmi_rsp_data_i,
    input  logic                core_halt_req_i,
    input  logic                core_rd_wr_en_i,
    input  logic                core_rd_wr_i,
    input  logic [15:0]         core_rd_wr_address_i,
    input  logic [31:0]         core_wr_data_i,
    input  logic                chk_rsp_i,
    input  logic [31:0]         exp_rsp_i,
    input  logic [1:0]          exp_halt_i,
    input  logic                chk_port_i,
    input  logic                exp_en_i,
    input  logic                exp_wr_i,
    input  logic [15:0]         exp_addr_i,
    input  logic [31:0]         exp_wdata_i,
    output int                  error_count_o,
    output int                  check_count_o
);

    initial begin
        error_count_o = 0;
        check_count_o = 0;
    end

    task automatic compare(input string label, input logic [31:0] expected,
                           input logic [31:0] actual);
        check_count_o++;
        if (actual !== expected) begin
            error_count_o++;
            $display("[ERROR] %0s %0s: expected 0x%h, actual 0x%h",
                     name_i, label, expected, actual);
        end
    endtask

    ////////////////////
    // Sampled before the edge updates any state
    ////////////////////

    always @(posedge clk_i) begin
        if (reset_i && active_i) begin
            // Every read step expects a response in the same cycle
            compare("rsp_valid", {31'b0, chk_rsp_i}, {31'b0, dmi_rsp_valid_i});
            if (dmi_req_valid_i) begin
                compare("rsp_op", {30'b0, dmi_req_op_i}, {30'b0, dmi_rsp_op_i});
            end
            if (chk_rsp_i) begin
                compare("rsp_data", exp_rsp_i, dmi_rsp_data_i);
            end
            if (exp_halt_i[1]) begin
                compare("halt_req", {31'b0, exp_halt_i[0]}, {31'b0, core_halt_req_i});
            end
            if (chk_port_i) begin
                compare("rd_wr_en", {31'b0, exp_en_i}, {31'b0, core_rd_wr_en_i});
                // Port fields only matter during the pulse
                if (exp_en_i) begin
                    compare("rd_wr", {31'b0, exp_wr_i}, {31'b0, core_rd_wr_i});
                    compare("address", {16'b0, exp_addr_i}, {16'b0, core_rd_wr_address_i});
                    if (exp_wr_i) begin
                        compare("wr_data", exp_wdata_i, core_wr_data_i);
                    end
                end
            end
        end
    end

endmodule

//--- test/dm_tb.sv
`timescale 1ns/1ps

module dm_tb;

    localparam int RESET_CYCLES = 16;
    localparam int MAX_STEPS    = 40;

    localparam dm_dmi_pkg::dmi_op_e NP = dm_dmi_pkg::NOP;
    localparam dm_dmi_pkg::dmi_op_e RD = dm_dmi_pkg::READ;
    localparam dm_dmi_pkg::dmi_op_e WR = dm_dmi_pkg::WRITE;

    // Halt request column, check bit then value
    localparam logic [1:0] HX = 2'b00;
    localparam logic [1:0] H0 = 2'b10;
    localparam logic [1:0] H1 = 2'b11;

    // DMStatus and AbstractCS bits at their standard positions
    localparam logic [31:0] ALLHALTED    = 32'h0000_0200;
    localparam logic [31:0] ALLRUNNING   = 32'h0000_0800;
    localparam logic [31:0] ALLRESUMEACK = 32'h0002_0000;
    localparam logic [31:0] BUSY         = 32'h0000_1000;

    typedef struct packed {
        logic [95:0]         name;
        dm_dmi_pkg::dmi_op_e op;
        logic [6:0]          addr;
        logic [31:0]         data;
        logic [1:0]          halt;
        logic                halt_ack;
        logic                resume_ack;
        logic                ebreak;
        logic [31:0]         rd_data;
        logic                chk_rsp;
        logic [31:0]         exp_rsp;
        logic                chk_port;
        logic                exp_en;
        logic                exp_wr;
        logic [15:0]         exp_addr;
        logic [31:0]         exp_wdata;
    } step_t;

    logic                clk;
    logic                reset_n;
    logic                active;
    step_t               cur;
    step_t               steps [MAX_STEPS];
    int                  n_steps;
    int                  cycles = 0;
    int                  timeout_cycles = MAX_STEPS + RESET_CYCLES + 20;
    int                  error_count;
    int                  check_count;
    logic                rsp_valid;
    dm_dmi_pkg::dmi_op_e rsp_op;
    logic [31:0]         rsp_data;
    logic                halt_req;
    logic                rd_wr_en;
    logic                rd_wr;
    logic [15:0]         rd_wr_addr;
    logic [31:0]         wr_data;

    dm_top DUT (
        .clk_i                (clk),
        .reset_i              (reset_n),
        .dmi_req_valid_i      (cur.op != NP),
        .dmi_req_op_i         (cur.op),
        .dmi_req_address_i    (cur.addr),
        .dmi_req_data_i       (cur.data),
        .dmi_rsp_valid_o      (rsp_valid),
        .dmi_rsp_op_o         (rsp_op),
        .dmi_rsp_data_o       (rsp_data),
        .core_halt_ack_i      (cur.halt_ack),
        .core_resume_ack_i    (cur.resume_ack),
        .core_ebreak_i        (cur.ebreak),
        .core_rd_data_i       (cur.rd_data),
        .core_halt_req_o      (halt_req),
        .core_rd_wr_en_o      (rd_wr_en),
        .core_rd_wr_o         (rd_wr),
        .core_rd_wr_address_o (rd_wr_addr),
        .core_wr_data_o       (wr_data)
    );

    dm_checker u_checker (
        .clk_i (clk), .reset_i (reset_n), .active_i (active), .name_i (cur.name),
        .dmi_req_valid_i (cur.op != NP), .dmi_req_op_i (cur.op),
        .dmi_rsp_valid_i (rsp_valid), .dmi_rsp_op_i (rsp_op), .dmi_rsp_data_i (rsp_data),
        .core_halt_req_i (halt_req), .core_rd_wr_en_i (rd_wr_en), .core_rd_wr_i (rd_wr),
        .core_rd_wr_address_i (rd_wr_addr), .core_wr_data_i (wr_data),
        .chk_rsp_i (cur.chk_rsp), .exp_rsp_i (cur.exp_rsp), .exp_halt_i (cur.halt),
        .chk_port_i (cur.chk_port), .exp_en_i (cur.exp_en), .exp_wr_i (cur.exp_wr),
        .exp_addr_i (cur.exp_addr), .exp_wdata_i (cur.exp_wdata),
        .error_count_o (error_count), .check_count_o (check_count)
    );

    ////////////////////
    // Table building
    ////////////////////

    // For reads the data column is also the expected response
    task automatic add_step(input logic [95:0] name, input dm_dmi_pkg::dmi_op_e op,
                            input logic [6:0] addr, input logic [31:0] data,
                            input logic [1:0] halt);
        step_t s;
        s         = '0;
        s.name    = name;
        s.op      = op;
        s.addr    = addr;
        s.data    = data;
        s.halt    = halt;
        s.chk_rsp = (op == RD);
        s.exp_rsp = data;
        steps[n_steps] = s;
        n_steps++;
    endtask

    task automatic drive_core(input logic halt_ack, input logic resume_ack,
                              input logic [31:0] rd_data);
        step_t s;
        s            = steps[n_steps-1];
        s.halt_ack   = halt_ack;
        s.resume_ack = resume_ack;
        s.rd_data    = rd_data;
        steps[n_steps-1] = s;
    endtask

    task automatic expect_port(input logic en, input logic wr, input logic [15:0] addr,
                               input logic [31:0] wdata);
        step_t s;
        s           = steps[n_steps-1];
        s.chk_port  = 1'b1;
        s.exp_en    = en;
        s.exp_wr    = wr;
        s.exp_addr  = addr;
        s.exp_wdata = wdata;
        steps[n_steps-1] = s;
    endtask

    task automatic build_table();
        // Reset state
        add_step("rst_idle", NP, 7'h00, 32'h0, HX);
        add_step("rst_status", RD, dm_dmi_pkg::ADDR_DMSTATUS, ALLRUNNING, H0);
        // Halt request then ack from the core
        add_step("halt_wr", WR, dm_dmi_pkg::ADDR_DMCONTROL, 32'h8000_0001, H0);
        add_step("halt_wait", NP, 7'h00, 32'h0, H0);
        add_step("halt_ack", NP, 7'h00, 32'h0, H1);
        drive_core(1'b1, 1'b0, 32'h0);
        add_step("halt_idle", NP, 7'h00, 32'h0, H1);
        add_step("halt_status", RD, dm_dmi_pkg::ADDR_DMSTATUS, ALLHALTED, H1);
        // Abstract write of regno 0x1005
        add_step("aw_data0", WR, dm_dmi_pkg::ADDR_DATA0, 32'h1234_5678, H1);
        add_step("aw_cmd", WR, dm_dmi_pkg::ADDR_COMMAND, 32'h0023_1005, H1);
        add_step("aw_wait", NP, 7'h00, 32'h0, H1);
        add_step("aw_start", NP, 7'h00, 32'h0, H1);
        expect_port(1'b0, 1'b0, 16'h0, 32'h0);
        add_step("aw_pulse", NP, 7'h00, 32'h0, H1);
        expect_port(1'b1, 1'b1, 16'h1005, 32'h1234_5678);
        add_step("aw_done", NP, 7'h00, 32'h0, H1);
        expect_port(1'b0, 1'b0, 16'h0, 32'h0);
        // Abstract read of regno 0x1008 with busy gating
        add_step("ar_cmd", WR, dm_dmi_pkg::ADDR_COMMAND, 32'h0022_1008, H1);
        add_step("ar_wait", NP, 7'h00, 32'h0, H1);
        add_step("ar_busy_d0", RD, dm_dmi_pkg::ADDR_DATA0, 32'h0, H1);
        expect_port(1'b0, 1'b0, 16'h0, 32'h0);
        add_step("ar_pulse", RD, dm_dmi_pkg::ADDR_ABSTRACTCS, BUSY, H1);
        drive_core(1'b0, 1'b0, 32'hcafe_0042);
        expect_port(1'b1, 1'b0, 16'h1008, 32'h0);
        add_step("ar_locked", WR, dm_dmi_pkg::ADDR_DATA0, 32'hdead_beef, H1);
        expect_port(1'b0, 1'b0, 16'h0, 32'h0);
        add_step("ar_idle", NP, 7'h00, 32'h0, H1);
        add_step("ar_cs_idle", RD, dm_dmi_pkg::ADDR_ABSTRACTCS, 32'h0, H1);
        add_step("ar_d0_read", RD, dm_dmi_pkg::ADDR_DATA0, 32'hcafe_0042, H1);
        // Resume with the ack held until the status read
        add_step("rs_wr", WR, dm_dmi_pkg::ADDR_DMCONTROL, 32'h4000_0001, H1);
        add_step("rs_wait", NP, 7'h00, 32'h0, H1);
        add_step("rs_ack", NP, 7'h00, 32'h0, H0);
        drive_core(1'b0, 1'b1, 32'h0);
        add_step("rs_hold", NP, 7'h00, 32'h0, H0);
        drive_core(1'b0, 1'b1, 32'h0);
        add_step("rs_status", RD, dm_dmi_pkg::ADDR_DMSTATUS, ALLRUNNING | ALLRESUMEACK, H0);
        drive_core(1'b0, 1'b1, 32'h0);
        add_step("rs_dmcontrol", RD, dm_dmi_pkg::ADDR_DMCONTROL, 32'h0000_0001, H0);
        add_step("end_idle", NP, 7'h00, 32'h0, H0);
    endtask

    ////////////////////
    // Clock, run, timeout
    ////////////////////

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cur     = '0;
        active  = 1'b0;
        reset_n = 1'b0;
        n_steps = 0;
        build_table();
        timeout_cycles = n_steps + RESET_CYCLES + 20;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        for (int i = 0; i < n_steps; i++) begin
            @(negedge clk);
            cur    = steps[i];
            active = 1'b1;
        end
        @(negedge clk);
        cur    = '0;
        active = 1'b0;
        $display("Steps: %0d, checks: %0d, errors: %0d", n_steps, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Run stalled after %0d cycles before the table finished", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule

//--- verilog.f
source/dm_dmi_pkg.sv
source/dm_reg_pkg.sv
source/dm_hart_ctrl.sv
source/dm_dmi_regfile.sv
source/dm_status_read.sv
source/dm_top.sv
test/dm_checker.sv
test/dm_tb.sv
